// ==== src/div_pkg.sv ====
package div_pkg;

    // RISC-V M-extension divide opcodes handled by the unit
    typedef enum logic [1:0] {
        DIV_S = 2'b00,
        DIV_U = 2'b01,
        REM_S = 2'b10,
        REM_U = 2'b11
    } div_op_e;

    // operand width used when the top level is not overridden
    localparam int DIV_WIDTH_DEFAULT = 32;

    // physical register tag width of the back end
    localparam int TAG_WIDTH_DEFAULT = 8;

    // the carried program counter is fixed at one word
    localparam int PC_WIDTH = 32;

endpackage

// ==== src/div_if.sv ====
`timescale 1ns/1ns

// one division in flight between two pipeline sections
interface div_if import div_pkg::*; #(
    parameter int WIDTH     = DIV_WIDTH_DEFAULT,
    parameter int TAG_WIDTH = TAG_WIDTH_DEFAULT
) ();

    logic                 valid;
    div_op_e              op;
    logic [TAG_WIDTH-1:0] tag;
    logic [PC_WIDTH-1:0]  pc;

    // partial remainder and the dividend that turns into the quotient
    logic [WIDTH-1:0]     rem;
    logic [WIDTH-1:0]     quo;
    logic [WIDTH-1:0]     divisor;

    // sign correction and zero-divisor handling for the last section
    logic                 neg_quo;
    logic                 neg_rem;
    logic                 div_zero;
    logic [WIDTH-1:0]     dividend_orig;

    modport source (
        output valid, op, tag, pc, rem, quo, divisor,
        output neg_quo, neg_rem, div_zero, dividend_orig
    );

    modport sink (
        input valid, op, tag, pc, rem, quo, divisor,
        input neg_quo, neg_rem, div_zero, dividend_orig
    );

endinterface

// ==== src/div_stage.sv ====
`timescale 1ns/1ns

module div_stage import div_pkg::*; #(
    parameter int WIDTH     = DIV_WIDTH_DEFAULT,
    parameter int TAG_WIDTH = TAG_WIDTH_DEFAULT
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    div_if.sink   in,
    div_if.source out
);

    logic [WIDTH:0]   trial;
    logic [WIDTH+1:0] diff;
    logic             fits;
    logic [WIDTH-1:0] rem_next;
    logic [WIDTH-1:0] quo_next;

    // one restoring step brings down the next dividend bit and tries the divisor
    always_comb begin
        trial    = {in.rem, in.quo[WIDTH-1]};
        diff     = {1'b0, trial} - {2'b00, in.divisor};
        fits     = ~diff[WIDTH+1];
        rem_next = fits ? diff[WIDTH-1:0] : trial[WIDTH-1:0];

        // the freed low bit of quo collects the new quotient bit
        quo_next = {in.quo[WIDTH-2:0], fits};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= in.valid & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.rem           <= rem_next;
            out.quo           <= quo_next;
            out.divisor       <= in.divisor;
            out.op            <= in.op;
            out.tag           <= in.tag;
            out.pc            <= in.pc;
            out.neg_quo       <= in.neg_quo;
            out.neg_rem       <= in.neg_rem;
            out.div_zero      <= in.div_zero;
            out.dividend_orig <= in.dividend_orig;
        end
    end

endmodule

// ==== src/div_pipeline.sv ====
`timescale 1ns/1ns

module div_pipeline import div_pkg::*; #(
    parameter int WIDTH     = DIV_WIDTH_DEFAULT,
    parameter int TAG_WIDTH = TAG_WIDTH_DEFAULT
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  flush,
    div_if.sink   in,
    div_if.source out
);

    // inner stage boundaries that lie between the two ports
    div_if #(
        .WIDTH     (WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) link [0:WIDTH-2] ();

    genvar i;
    generate
        for (i = 0; i < WIDTH; i = i + 1) begin : g_stage
            if (i == 0) begin : g_first
                div_stage #(
                    .WIDTH     (WIDTH),
                    .TAG_WIDTH (TAG_WIDTH)
                ) u_stage (
                    .clk   (clk),
                    .reset (reset),
                    .flush (flush),
                    .in    (in),
                    .out   (link[0])
                );
            end else if (i == WIDTH - 1) begin : g_last
                div_stage #(
                    .WIDTH     (WIDTH),
                    .TAG_WIDTH (TAG_WIDTH)
                ) u_stage (
                    .clk   (clk),
                    .reset (reset),
                    .flush (flush),
                    .in    (link[i-1]),
                    .out   (out)
                );
            end else begin : g_mid
                div_stage #(
                    .WIDTH     (WIDTH),
                    .TAG_WIDTH (TAG_WIDTH)
                ) u_stage (
                    .clk   (clk),
                    .reset (reset),
                    .flush (flush),
                    .in    (link[i-1]),
                    .out   (link[i])
                );
            end
        end
    endgenerate

endmodule

// ==== src/div_operand_prep.sv ====
`timescale 1ns/1ns

module div_operand_prep import div_pkg::*; #(
    parameter int WIDTH     = DIV_WIDTH_DEFAULT,
    parameter int TAG_WIDTH = TAG_WIDTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  logic                 flush,
    input  div_op_e              op,
    input  logic [WIDTH-1:0]     dividend,
    input  logic [WIDTH-1:0]     divisor,
    input  logic [TAG_WIDTH-1:0] tag,
    input  logic [PC_WIDTH-1:0]  pc,
    div_if.source                out
);

    logic             is_signed;
    logic             dividend_neg;
    logic             divisor_neg;
    logic [WIDTH-1:0] dividend_mag;
    logic [WIDTH-1:0] divisor_mag;

    always_comb begin
        is_signed    = (op == DIV_S) || (op == REM_S);
        dividend_neg = is_signed && dividend[WIDTH-1];
        divisor_neg  = is_signed && divisor[WIDTH-1];

        // the most negative value maps onto itself, read as unsigned magnitude
        dividend_mag = dividend_neg ? -dividend : dividend;
        divisor_mag  = divisor_neg ? -divisor : divisor;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out.valid <= 1'b0;
        end else begin
            // an issue in a flush cycle is dropped
            out.valid <= issue & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out.op            <= op;
            out.tag           <= tag;
            out.pc            <= pc;
            out.rem           <= '0;
            out.quo           <= dividend_mag;
            out.divisor       <= divisor_mag;
            out.neg_quo       <= dividend_neg ^ divisor_neg;
            out.neg_rem       <= dividend_neg;
            out.div_zero      <= (divisor == '0);
            out.dividend_orig <= dividend;
        end
    end

endmodule

// ==== src/div_result_fixup.sv ====
`timescale 1ns/1ns

module div_result_fixup import div_pkg::*; #(
    parameter int WIDTH     = DIV_WIDTH_DEFAULT,
    parameter int TAG_WIDTH = TAG_WIDTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    div_if.sink                  in,
    output logic                 done,
    output logic [WIDTH-1:0]     result,
    output logic [TAG_WIDTH-1:0] tag_out,
    output logic [PC_WIDTH-1:0]  pc_out
);

    logic [WIDTH-1:0] quotient;
    logic [WIDTH-1:0] remainder;
    logic [WIDTH-1:0] result_next;
    logic             want_quotient;

    always_comb begin
        // a zero divisor already leaves all ones in quo, so it must not be negated
        if (in.neg_quo && !in.div_zero) begin
            quotient = -in.quo;
        end else begin
            quotient = in.quo;
        end

        if (in.div_zero) begin
            remainder = in.dividend_orig;
        end else if (in.neg_rem) begin
            remainder = -in.rem;
        end else begin
            remainder = in.rem;
        end

        // most negative by minus one needs nothing special because the magnitudes work out
        want_quotient = (in.op == DIV_S) || (in.op == DIV_U);
        result_next   = want_quotient ? quotient : remainder;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done    <= 1'b0;
            result  <= '0;
            tag_out <= '0;
            pc_out  <= '0;
        end else begin
            done <= in.valid & ~flush;
            if (in.valid) begin
                result  <= result_next;
                tag_out <= in.tag;
                pc_out  <= in.pc;
            end
        end
    end

endmodule

// ==== src/div_unit.sv ====
`timescale 1ns/1ns

module div_unit import div_pkg::*; #(
    parameter int WIDTH     = DIV_WIDTH_DEFAULT,
    parameter int TAG_WIDTH = TAG_WIDTH_DEFAULT
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  div_op_e              op,
    input  logic [WIDTH-1:0]     dividend,
    input  logic [WIDTH-1:0]     divisor,
    input  logic [TAG_WIDTH-1:0] tag,
    input  logic [PC_WIDTH-1:0]  pc,
    input  logic                 flush,
    output logic                 done,
    output logic [WIDTH-1:0]     result,
    output logic [TAG_WIDTH-1:0] tag_out,
    output logic [PC_WIDTH-1:0]  pc_out
);

    div_if #(.WIDTH(WIDTH), .TAG_WIDTH(TAG_WIDTH)) prep_bus ();
    div_if #(.WIDTH(WIDTH), .TAG_WIDTH(TAG_WIDTH)) core_bus ();

    div_operand_prep #(
        .WIDTH     (WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_prep (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .flush    (flush),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .tag      (tag),
        .pc       (pc),
        .out      (prep_bus)
    );

    // one restoring step per stage, WIDTH stages in all
    div_pipeline #(
        .WIDTH     (WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_pipeline (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .in    (prep_bus),
        .out   (core_bus)
    );

    div_result_fixup #(
        .WIDTH     (WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_fixup (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .in      (core_bus),
        .done    (done),
        .result  (result),
        .tag_out (tag_out),
        .pc_out  (pc_out)
    );

endmodule

// ==== verification/div_unit_tests.svh ====
// drives one operation at the next falling edge and leaves issue high
task automatic issue_op(input div_op_e op_i, input logic [WIDTH-1:0] a,
                        input logic [WIDTH-1:0] b);
    pending_t entry;
    @(negedge clk);
    issue             = 1'b1;
    op                = op_i;
    dividend          = a;
    divisor           = b;
    tag               = next_tag;
    pc                = next_pc;
    entry.tag         = next_tag;
    entry.pc          = next_pc;
    entry.result      = expected_result(op_i, a, b);
    entry.issue_cycle = cycle;
    pending_q.push_back(entry);
    next_tag = next_tag + 1'b1;
    next_pc  = next_pc + 32'd4;
endtask

task automatic end_issue();
    @(negedge clk);
    issue = 1'b0;
endtask

task automatic issue_quotient_and_remainder(input div_op_e qop, input div_op_e rop,
                                            input logic [WIDTH-1:0] a,
                                            input logic [WIDTH-1:0] b);
    issue_op(qop, a, b);
    end_issue();
    issue_op(rop, a, b);
    end_issue();
endtask

task automatic wait_for_drain();
    while (pending_q.size() != 0) begin
        @(negedge clk);
    end
    @(negedge clk);
endtask

task automatic flush_pipeline(input logic with_issue);
    @(negedge clk);
    flush    = 1'b1;
    issue    = with_issue;
    op       = DIV_U;
    dividend = 32'h0000_0bad;
    divisor  = 32'd1;
    tag      = next_tag;
    pc       = next_pc;
    next_tag = next_tag + 1'b1;
    next_pc  = next_pc + 32'd4;
    @(negedge clk);
    flush = 1'b0;
    issue = 1'b0;
    // anything that has not completed by now was killed
    pending_q.delete();
endtask

task automatic expect_no_done(input int cycles);
    int pulses;
    pulses = 0;
    repeat (cycles) begin
        @(negedge clk);
        if (done === 1'b1) begin
            pulses++;
        end
    end
    if (pulses != 0) begin
        $display("%0d done pulses came from operations that a flush should have killed", pulses);
        chk_fail++;
    end else begin
        chk_pass++;
    end
endtask

task automatic check_reset_outputs(input string when_text);
    int errors;
    errors = 0;
    if (done !== 1'b0) begin
        $display("FAIL done %s: expected 0x0, got 0x%h", when_text, done);
        errors++;
    end
    if (result !== '0) begin
        $display("FAIL result %s: expected 0x0, got 0x%h", when_text, result);
        errors++;
    end
    if (tag_out !== '0) begin
        $display("FAIL tag_out %s: expected 0x0, got 0x%h", when_text, tag_out);
        errors++;
    end
    if (pc_out !== '0) begin
        $display("FAIL pc_out %s: expected 0x0, got 0x%h", when_text, pc_out);
        errors++;
    end
    chk_fail += errors;
    chk_pass += 4 - errors;
endtask

task automatic report_test(input string name, input int start_errors);
    $display("%s finished with %0d errors", name, error_total() - start_errors);
endtask

task automatic test_reset_state();
    int start_errors;
    start_errors = error_total();
    reset = 1'b1;
    repeat (3) begin
        @(negedge clk);
        check_reset_outputs("during reset");
    end
    reset = 1'b0;
    @(negedge clk);
    check_reset_outputs("after reset");
    report_test("reset state", start_errors);
endtask

task automatic test_unsigned();
    int               start_errors;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [31:0]      shift;
    start_errors = error_total();
    issue_quotient_and_remainder(DIV_U, REM_U, 32'd100, 32'd7);
    issue_quotient_and_remainder(DIV_U, REM_U, 32'd7, 32'd100);
    issue_quotient_and_remainder(DIV_U, REM_U, 32'hffff_ffff, 32'd1);
    issue_quotient_and_remainder(DIV_U, REM_U, 32'hffff_ffff, 32'hffff_ffff);
    issue_quotient_and_remainder(DIV_U, REM_U, 32'h8000_0000, 32'd3);
    issue_quotient_and_remainder(DIV_U, REM_U, 32'h1234_5678, 32'h0000_1000);
    repeat (10) begin
        a     = $random(seed);
        b     = $random(seed);
        shift = $random(seed);
        b     = b >> shift[4:0];
        issue_quotient_and_remainder(DIV_U, REM_U, a, b);
    end
    wait_for_drain();
    report_test("unsigned operations", start_errors);
endtask

task automatic test_signed();
    int               start_errors;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    start_errors = error_total();
    issue_quotient_and_remainder(DIV_S, REM_S, 32'd20, 32'd6);
    issue_quotient_and_remainder(DIV_S, REM_S, 32'hffff_ffec, 32'd6);
    issue_quotient_and_remainder(DIV_S, REM_S, 32'd20, 32'hffff_fffa);
    issue_quotient_and_remainder(DIV_S, REM_S, 32'hffff_ffec, 32'hffff_fffa);
    issue_quotient_and_remainder(DIV_S, REM_S, MOST_NEG, 32'hffff_ffff);
    issue_quotient_and_remainder(DIV_S, REM_S, 32'hffff_ffff, 32'd2);
    repeat (4) begin
        a = $random(seed);
        b = $random(seed);
        b = $signed(b) >>> 20;
        issue_quotient_and_remainder(DIV_S, REM_S, a, b);
    end
    wait_for_drain();
    report_test("signed operations", start_errors);
endtask

task automatic test_div_zero();
    int start_errors;
    start_errors = error_total();
    issue_quotient_and_remainder(DIV_U, REM_U, 32'h1234_5678, '0);
    issue_quotient_and_remainder(DIV_S, REM_S, 32'h1234_5678, '0);
    issue_quotient_and_remainder(DIV_S, REM_S, MOST_NEG, '0);
    // a negative dividend must not flip the all-ones quotient
    issue_quotient_and_remainder(DIV_S, REM_S, 32'hffff_fff0, '0);
    issue_quotient_and_remainder(DIV_U, REM_U, '0, '0);
    issue_quotient_and_remainder(DIV_S, REM_S, 32'hffff_ffff, '0);
    wait_for_drain();
    report_test("division by zero", start_errors);
endtask

task automatic test_throughput();
    int               start_errors;
    logic [31:0]      rnd;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    start_errors = error_total();
    repeat (40) begin
        rnd = $random(seed);
        a   = $random(seed);
        b   = $random(seed);
        b   = b >> rnd[6:2];
        issue_op(div_op_e'(rnd[1:0]), a, b);
    end
    end_issue();
    wait_for_drain();
    report_test("full throughput", start_errors);
endtask

task automatic test_flush();
    int start_errors;
    start_errors = error_total();
    repeat (5) begin
        issue_op(DIV_U, 32'd1000, 32'd9);
    end
    end_issue();
    repeat (3) @(negedge clk);
    flush_pipeline(1'b0);
    expect_no_done(LATENCY + 2);

    // the oldest of these sits at the result stage input when the flush hits
    repeat (4) begin
        issue_op(REM_S, 32'hffff_fc18, 32'd7);
        end_issue();
    end
    repeat (LATENCY - 9) @(negedge clk);
    flush_pipeline(1'b0);
    expect_no_done(LATENCY + 2);

    issue_op(DIV_S, 32'd77, 32'd7);
    flush_pipeline(1'b1);
    expect_no_done(LATENCY + 2);

    repeat (4) begin
        issue_op(DIV_S, 32'hffff_ff00, 32'd3);
        end_issue();
    end
    wait_for_drain();
    report_test("flush", start_errors);
endtask

// ==== verification/div_unit_tb.sv ====
`timescale 1ns/1ns

module div_unit_tb import div_pkg::*; ();

    localparam int WIDTH     = DIV_WIDTH_DEFAULT;
    localparam int TAG_WIDTH = TAG_WIDTH_DEFAULT;
    localparam int LATENCY   = WIDTH + 2;
    localparam int NUM_OPS   = 120;
    localparam int NUM_TESTS = 6;

    // two cycles per issued operation plus a few drains and idle windows per test
    localparam int WATCHDOG_NS = (NUM_OPS * 2 + NUM_TESTS * 3 * (LATENCY + 4)) * 10 + 500;

    localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
        logic [PC_WIDTH-1:0]  pc;
        logic [WIDTH-1:0]     result;
        logic [31:0]          issue_cycle;
    } pending_t;

    logic                 clk;
    logic                 reset;
    logic                 issue;
    logic                 flush;
    div_op_e              op;
    logic [WIDTH-1:0]     dividend;
    logic [WIDTH-1:0]     divisor;
    logic [TAG_WIDTH-1:0] tag;
    logic [PC_WIDTH-1:0]  pc;
    logic                 done;
    logic [WIDTH-1:0]     result;
    logic [TAG_WIDTH-1:0] tag_out;
    logic [PC_WIDTH-1:0]  pc_out;

    pending_t             pending_q[$];
    logic [31:0]          cycle = '0;
    logic [TAG_WIDTH-1:0] next_tag = '0;
    logic [PC_WIDTH-1:0]  next_pc = 32'h8000_0000;
    integer               seed = 32'h588b_38c0;
    int                   mon_pass = 0;
    int                   mon_fail = 0;
    int                   chk_pass = 0;
    int                   chk_fail = 0;

    div_unit #(
        .WIDTH     (WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .op       (op),
        .dividend (dividend),
        .divisor  (divisor),
        .tag      (tag),
        .pc       (pc),
        .flush    (flush),
        .done     (done),
        .result   (result),
        .tag_out  (tag_out),
        .pc_out   (pc_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // a value read at a falling edge equals the value seen at the next rising edge
    always @(posedge clk) begin
        cycle <= cycle + 1'b1;
    end

    // RISC-V divide semantics, including the zero-divisor and overflow rules
    function automatic logic [WIDTH-1:0] expected_result(input div_op_e op_i,
                                                         input logic [WIDTH-1:0] a,
                                                         input logic [WIDTH-1:0] b);
        logic signed [WIDTH-1:0] sa;
        logic signed [WIDTH-1:0] sb;
        logic [WIDTH-1:0]        q;
        logic [WIDTH-1:0]        r;
        sa = a;
        sb = b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (op_i == DIV_S || op_i == REM_S) begin
            if (a == MOST_NEG && b == '1) begin
                q = a;
                r = '0;
            end else begin
                q = sa / sb;
                r = sa % sb;
            end
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op_i == DIV_S || op_i == DIV_U) ? q : r;
    endfunction

    function automatic int error_total();
        return mon_fail + chk_fail;
    endfunction

    always @(posedge clk) begin : monitor
        pending_t expected;
        if (done === 1'b1) begin
            if (pending_q.size() == 0) begin
                $display("unexpected done pulse at cycle %0d with no operation in flight", cycle);
                mon_fail++;
            end else begin
                expected = pending_q.pop_front();
                if (result !== expected.result) begin
                    $display("FAIL result: expected 0x%h, got 0x%h (tag 0x%h)",
                             expected.result, result, expected.tag);
                    mon_fail++;
                end else begin
                    mon_pass++;
                end
                if (tag_out !== expected.tag) begin
                    $display("FAIL tag_out: expected 0x%h, got 0x%h", expected.tag, tag_out);
                    mon_fail++;
                end else begin
                    mon_pass++;
                end
                if (pc_out !== expected.pc) begin
                    $display("FAIL pc_out: expected 0x%h, got 0x%h", expected.pc, pc_out);
                    mon_fail++;
                end else begin
                    mon_pass++;
                end
                if (cycle - expected.issue_cycle != 32'(LATENCY)) begin
                    $display("done for tag 0x%h came %0d cycles after its issue, not %0d",
                             expected.tag, cycle - expected.issue_cycle, LATENCY);
                    mon_fail++;
                end else begin
                    mon_pass++;
                end
            end
        end
    end

    `include "div_unit_tests.svh"

    initial begin
        issue    = 1'b0;
        flush    = 1'b0;
        op       = DIV_U;
        dividend = '0;
        divisor  = '0;
        tag      = '0;
        pc       = '0;
        reset    = 1'b1;
        test_reset_state();
        test_unsigned();
        test_signed();
        test_div_zero();
        test_throughput();
        test_flush();
        $display("checks passed: %0d, checks failed: %0d", mon_pass + chk_pass, error_total());
        if (error_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d operations still expected",
                 WATCHDOG_NS, pending_q.size());
        $display("Test failed");
        $finish;
    end

endmodule

// ==== div_unit.f ====
+incdir+verification
src/div_pkg.sv
src/div_if.sv
src/div_stage.sv
src/div_pipeline.sv
src/div_operand_prep.sv
src/div_result_fixup.sv
src/div_unit.sv
verification/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the divide unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary \
    --timescale 1ns/1ns \
    --top-module div_unit_tb \
    -f div_unit.f \
    --Mdir obj_dir \
    -o div_unit_sim

./obj_dir/div_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without a reported failure"
